//--- all.f
riscv_pkg.sv
alu.sv
decoder.sv
reg_file.sv
instr_mem.sv
data_mem.sv
host_apb.sv
cpu_core.sv
sort_soc.sv
tb_sort_soc.sv

//--- alu.sv
`timescale 1ns/1ps

module alu
    import riscv_pkg::*;
(
    input  xlen_t   a,
    input  xlen_t   b,
    input  alu_op_t op,
    output xlen_t   result
);

    logic lt_s;

    // signed less-than shared by blt and bge
    assign lt_s = ($signed(a) < $signed(b));

    always_comb begin
        result = '0;
        case (op)
            alu_add: result = a + b;
            alu_sub: result = a - b;
            alu_and: result = a & b;
            // compares land in bit 0
            alu_eq:  result[0] = (a == b);
            alu_ne:  result[0] = (a != b);
            alu_lt:  result[0] = lt_s;
            alu_ge:  result[0] = !lt_s;
            default: result = '0;
        endcase
    end

endmodule

//--- cpu_core.sv
`timescale 1ns/1ps

module cpu_core
    import riscv_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       start,
    input  xlen_t      instr,
    input  xlen_t      dmem_rdata,
    output imem_addr_t pc_word,
    output logic       dmem_we,
    output dmem_addr_t dmem_addr,
    output xlen_t      dmem_wdata,
    output logic       running,
    output logic       halted
);

    run_state_t state;
    xlen_t      pc;
    xlen_t      pc_next;
    reg_addr_t  rs1;
    reg_addr_t  rs2;
    reg_addr_t  rd;
    alu_op_t    alu_op;
    logic       use_imm;
    logic       reg_we;
    logic       mem_we;
    logic       load_sel;
    logic       is_branch;
    logic       is_jal;
    xlen_t      imm;
    xlen_t      rdata1;
    xlen_t      rdata2;
    xlen_t      alu_b;
    xlen_t      alu_res;
    xlen_t      wb_data;
    logic       halt_hit;
    logic       take;
    logic       exec;

    ////////////////////////////////////////////////////////////////////////////
    // datapath
    ////////////////////////////////////////////////////////////////////////////

    decoder i_decoder (
        .instr     (instr),
        .rs1       (rs1),
        .rs2       (rs2),
        .rd        (rd),
        .alu_op    (alu_op),
        .use_imm   (use_imm),
        .reg_we    (reg_we),
        .mem_we    (mem_we),
        .load_sel  (load_sel),
        .is_branch (is_branch),
        .is_jal    (is_jal),
        .imm       (imm)
    );

    // jal to itself stops the core
    assign halt_hit = is_jal && (imm == '0);
    // writes only while running, never on the halt word
    assign exec     = running && !halt_hit;

    reg_file i_reg_file (
        .clk    (clk),
        .rst    (rst),
        .we     (reg_we && exec),
        .raddr1 (rs1),
        .raddr2 (rs2),
        .waddr  (rd),
        .wdata  (wb_data),
        .rdata1 (rdata1),
        .rdata2 (rdata2)
    );

    // immediate or rs2 on the b side
    assign alu_b = use_imm ? imm : rdata2;

    alu i_alu (
        .a      (rdata1),
        .b      (alu_b),
        .op     (alu_op),
        .result (alu_res)
    );

    // alu result indexes data memory by word
    assign dmem_we    = mem_we && exec;
    assign dmem_addr  = alu_res[dmem_aw-1:0];
    assign dmem_wdata = rdata2;
    assign wb_data    = load_sel ? dmem_rdata : alu_res;

    // branch on compare bit, jal always
    assign take    = (is_branch && alu_res[0]) || is_jal;
    assign pc_next = take ? (pc + imm) : (pc + pc_step);
    assign pc_word = pc[imem_aw+1:2];

    ////////////////////////////////////////////////////////////////////////////
    // run control
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= st_idle;
            pc    <= '0;
        end else begin
            case (state)
                st_running: begin
                    // start ignored here
                    if (halt_hit) begin
                        state <= st_halted;
                    end else begin
                        pc <= pc_next;
                    end
                end
                default: begin
                    // idle or halted, start runs from pc 0
                    if (start) begin
                        state <= st_running;
                        pc    <= '0;
                    end
                end
            endcase
        end
    end

    assign running = (state == st_running);
    assign halted  = (state == st_halted);

endmodule

//--- data_mem.sv
`timescale 1ns/1ps

module data_mem
    import riscv_pkg::*;
(
    input  logic       clk,
    input  logic       core_we,
    input  dmem_addr_t core_addr,
    input  xlen_t      core_wdata,
    input  logic       host_we,
    input  dmem_addr_t host_addr,
    input  xlen_t      host_wdata,
    output xlen_t      core_rdata,
    output xlen_t      host_rdata
);

    // word array, indexed by word not byte
    xlen_t mem [dmem_words];

    // two write ports
    // host is locked out while the core runs so they never meet
    always_ff @(posedge clk) begin
        if (core_we) begin
            mem[core_addr] <= core_wdata;
        end
        if (host_we) begin
            mem[host_addr] <= host_wdata;
        end
    end

    // async reads on both sides
    assign core_rdata = mem[core_addr];
    assign host_rdata = mem[host_addr];

endmodule

//--- decoder.sv
`timescale 1ns/1ps

module decoder
    import riscv_pkg::*;
(
    input  xlen_t     instr,
    output reg_addr_t rs1,
    output reg_addr_t rs2,
    output reg_addr_t rd,
    output alu_op_t   alu_op,
    output logic      use_imm,
    output logic      reg_we,
    output logic      mem_we,
    output logic      load_sel,
    output logic      is_branch,
    output logic      is_jal,
    output xlen_t     imm
);

    logic [2:0] funct3;
    logic       f7_b30;
    imm_sel_t   imm_sel;

    // fixed register fields
    assign rs1    = instr[19:15];
    assign rs2    = instr[24:20];
    assign rd     = instr[11:7];
    assign funct3 = instr[14:12];
    assign f7_b30 = instr[30];

    ////////////////////////////////////////////////////////////////////////////
    // control decode
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        // defaults make an unknown word a no-op
        alu_op    = alu_add;
        use_imm   = 1'b0;
        reg_we    = 1'b0;
        mem_we    = 1'b0;
        load_sel  = 1'b0;
        is_branch = 1'b0;
        is_jal    = 1'b0;
        imm_sel   = imm_i;
        case (opcode_t'(instr[6:0]))
            op_imm: begin
                use_imm = 1'b1;
                if (funct3 == f3_add) begin
                    reg_we = 1'b1;
                end else if (funct3 == f3_and) begin
                    alu_op = alu_and;
                    reg_we = 1'b1;
                end
            end
            op_reg: begin
                // bit 30 splits add and sub
                case ({f7_b30, funct3})
                    {1'b0, f3_add}: reg_we = 1'b1;
                    {1'b1, f3_add}: begin
                        alu_op = alu_sub;
                        reg_we = 1'b1;
                    end
                    {1'b0, f3_and}: begin
                        alu_op = alu_and;
                        reg_we = 1'b1;
                    end
                    default: reg_we = 1'b0;
                endcase
            end
            op_load: begin
                // alu sum is the word index
                use_imm  = 1'b1;
                load_sel = 1'b1;
                reg_we   = (funct3 == f3_word);
            end
            op_store: begin
                use_imm = 1'b1;
                imm_sel = imm_s;
                mem_we  = (funct3 == f3_word);
            end
            op_branch: begin
                imm_sel   = imm_b;
                is_branch = 1'b1;
                case (funct3)
                    f3_beq:  alu_op = alu_eq;
                    f3_bne:  alu_op = alu_ne;
                    f3_blt:  alu_op = alu_lt;
                    f3_bge:  alu_op = alu_ge;
                    // other funct3 falls through
                    default: is_branch = 1'b0;
                endcase
            end
            op_jal: begin
                // no link write
                imm_sel = imm_j;
                is_jal  = 1'b1;
            end
            default: begin
                reg_we = 1'b0;
            end
        endcase
    end

    // sign-extended immediates, byte offsets
    always_comb begin
        case (imm_sel)
            imm_s:   imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            imm_b:   imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25],
                            instr[11:8], 1'b0};
            imm_j:   imm = {{11{instr[31]}}, instr[31], instr[19:12], instr[20],
                            instr[30:21], 1'b0};
            default: imm = {{20{instr[31]}}, instr[31:20]};
        endcase
    end

endmodule

//--- host_apb.sv
`timescale 1ns/1ps

module host_apb
    import riscv_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       psel,
    input  logic       penable,
    input  logic       pwrite,
    input  paddr_t     paddr,
    input  xlen_t      pwdata,
    input  logic       running,
    input  logic       halted,
    input  xlen_t      host_rdata,
    output xlen_t      prdata,
    output logic       pready,
    output logic       pslverr,
    output logic       start,
    output logic       imem_we,
    output imem_addr_t imem_waddr,
    output xlen_t      imem_wdata,
    output logic       host_we,
    output dmem_addr_t host_addr,
    output xlen_t      host_wdata
);

    logic setup_q;
    logic access;
    logic is_ctrl;
    logic is_imem;
    logic is_dmem;
    logic is_mem;
    logic bad_addr;
    logic blocked;
    logic wr_ok;

    // setup phase seen on the previous clock
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            setup_q <= 1'b0;
        end else begin
            setup_q <= psel && !penable;
        end
    end

    // access phase only right after a setup phase
    // so a held penable never repeats a strobe
    assign access = psel && penable && setup_q;

    ////////////////////////////////////////////////////////////////////////////
    // region decode
    ////////////////////////////////////////////////////////////////////////////

    assign is_ctrl  = (paddr == ctrl_addr);
    assign is_imem  = (paddr[15:region_lsb] == imem_base[15:region_lsb]);
    assign is_dmem  = (paddr[15:region_lsb] == dmem_base[15:region_lsb]);
    assign is_mem   = is_imem || is_dmem;
    assign bad_addr = !(is_ctrl || is_mem);
    // memories belong to the core while it runs
    assign blocked  = is_mem && running;

    // no wait states
    assign pready  = 1'b1;
    assign pslverr = access && (bad_addr || blocked);

    // write strobe for one clock at the end of the access phase
    assign wr_ok = access && pwrite && !bad_addr && !blocked;

    // start request from ctrl bit 0
    assign start = wr_ok && is_ctrl && pwdata[0];

    // instruction memory write port
    assign imem_we    = wr_ok && is_imem;
    assign imem_waddr = paddr[imem_aw+1:2];
    assign imem_wdata = pwdata;

    // data memory host port, address shared by reads and writes
    assign host_we    = wr_ok && is_dmem;
    assign host_addr  = paddr[dmem_aw+1:2];
    assign host_wdata = pwdata;

    ////////////////////////////////////////////////////////////////////////////
    // read data
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        prdata = '0;
        if (is_ctrl) begin
            prdata[0] = running;
            prdata[1] = halted;
        end else if (is_dmem && !running) begin
            prdata = host_rdata;
        end
        // imem is write only from the host, reads give zero
    end

endmodule

//--- instr_mem.sv
`timescale 1ns/1ps

module instr_mem
    import riscv_pkg::*;
(
    input  logic       clk,
    input  logic       we,
    input  imem_addr_t waddr,
    input  xlen_t      wdata,
    input  imem_addr_t pc_word,
    output xlen_t      instr
);

    // program store, contents survive reset
    xlen_t mem [imem_words];

    // host load port
    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
    end

    // fetch is combinational
    // so the core sees the word in the same cycle
    assign instr = mem[pc_word];

endmodule

//--- reg_file.sv
`timescale 1ns/1ps

module reg_file
    import riscv_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      we,
    input  reg_addr_t raddr1,
    input  reg_addr_t raddr2,
    input  reg_addr_t waddr,
    input  xlen_t     wdata,
    output xlen_t     rdata1,
    output xlen_t     rdata2
);

    xlen_t regs [32];

    // all registers start at zero
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && (waddr != '0)) begin
            regs[waddr] <= wdata;
        end
    end

    // x0 hardwired to zero
    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

//--- riscv_pkg.sv
package riscv_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // widths
    ////////////////////////////////////////////////////////////////////////////

    localparam int xlen    = 32;
    localparam int imem_aw = 8;
    localparam int dmem_aw = 8;

    // data word, register index, word indices, apb address
    typedef logic [xlen-1:0]    xlen_t;
    typedef logic [4:0]         reg_addr_t;
    typedef logic [imem_aw-1:0] imem_addr_t;
    typedef logic [dmem_aw-1:0] dmem_addr_t;
    typedef logic [15:0]        paddr_t;

    ////////////////////////////////////////////////////////////////////////////
    // instruction encodings
    ////////////////////////////////////////////////////////////////////////////

    // rv32i major opcodes kept by this core
    typedef enum logic [6:0] {
        op_imm    = 7'b0010011,
        op_reg    = 7'b0110011,
        op_load   = 7'b0000011,
        op_store  = 7'b0100011,
        op_branch = 7'b1100011,
        op_jal    = 7'b1101111
    } opcode_t;

    // funct3 values
    localparam logic [2:0] f3_add  = 3'b000;
    localparam logic [2:0] f3_and  = 3'b111;
    localparam logic [2:0] f3_word = 3'b010;
    localparam logic [2:0] f3_beq  = 3'b000;
    localparam logic [2:0] f3_bne  = 3'b001;
    localparam logic [2:0] f3_blt  = 3'b100;
    localparam logic [2:0] f3_bge  = 3'b101;

    // compares give 1 or 0 in bit 0
    typedef enum logic [3:0] {
        alu_add = 4'd0,
        alu_sub = 4'd1,
        alu_and = 4'd2,
        alu_eq  = 4'd3,
        alu_ne  = 4'd4,
        alu_lt  = 4'd5,
        alu_ge  = 4'd6
    } alu_op_t;

    typedef enum logic [1:0] {
        imm_i = 2'd0,
        imm_s = 2'd1,
        imm_b = 2'd2,
        imm_j = 2'd3
    } imm_sel_t;

    typedef enum logic [1:0] {
        st_idle    = 2'd0,
        st_running = 2'd1,
        st_halted  = 2'd2
    } run_state_t;

    ////////////////////////////////////////////////////////////////////////////
    // host address map and sizes
    ////////////////////////////////////////////////////////////////////////////

    localparam paddr_t ctrl_addr  = 16'h0000;
    localparam paddr_t imem_base  = 16'h1000;
    localparam paddr_t dmem_base  = 16'h2000;
    // 1 KiB per region, region picked by the bits above
    localparam int     region_lsb = 10;
    localparam int     imem_words = 256;
    localparam int     dmem_words = 256;
    localparam xlen_t  pc_step    = 32'd4;

endpackage

//--- run.sh
#!/bin/sh
# build and run the sort engine testbench with verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f all.f --top-module tb_sort_soc -o tb_sort_soc
./obj_dir/tb_sort_soc > sim.log 2>&1
cat sim.log

if grep -q "Errors found" sim.log; then
    echo "simulation failed"
    exit 1
fi
echo "simulation passed"

//--- sort_soc.sv
`timescale 1ns/1ps

module sort_soc
    import riscv_pkg::*;
(
    input  logic   clk,
    input  logic   rst,
    input  logic   psel,
    input  logic   penable,
    input  logic   pwrite,
    input  paddr_t paddr,
    input  xlen_t  pwdata,
    output xlen_t  prdata,
    output logic   pready,
    output logic   pslverr,
    output logic   running,
    output logic   halted
);

    logic       start;
    logic       imem_we;
    imem_addr_t imem_waddr;
    xlen_t      imem_wdata;
    logic       host_we;
    dmem_addr_t host_addr;
    xlen_t      host_wdata;
    xlen_t      host_rdata;
    imem_addr_t pc_word;
    xlen_t      instr;
    logic       dmem_we;
    dmem_addr_t dmem_addr;
    xlen_t      dmem_wdata;
    xlen_t      dmem_rdata;

    // host side
    host_apb i_host_apb (
        .clk        (clk),
        .rst        (rst),
        .psel       (psel),
        .penable    (penable),
        .pwrite     (pwrite),
        .paddr      (paddr),
        .pwdata     (pwdata),
        .running    (running),
        .halted     (halted),
        .host_rdata (host_rdata),
        .prdata     (prdata),
        .pready     (pready),
        .pslverr    (pslverr),
        .start      (start),
        .imem_we    (imem_we),
        .imem_waddr (imem_waddr),
        .imem_wdata (imem_wdata),
        .host_we    (host_we),
        .host_addr  (host_addr),
        .host_wdata (host_wdata)
    );

    // memories
    instr_mem i_instr_mem (
        .clk     (clk),
        .we      (imem_we),
        .waddr   (imem_waddr),
        .wdata   (imem_wdata),
        .pc_word (pc_word),
        .instr   (instr)
    );

    data_mem i_data_mem (
        .clk        (clk),
        .core_we    (dmem_we),
        .core_addr  (dmem_addr),
        .core_wdata (dmem_wdata),
        .host_we    (host_we),
        .host_addr  (host_addr),
        .host_wdata (host_wdata),
        .core_rdata (dmem_rdata),
        .host_rdata (host_rdata)
    );

    // processor
    cpu_core i_cpu_core (
        .clk        (clk),
        .rst        (rst),
        .start      (start),
        .instr      (instr),
        .dmem_rdata (dmem_rdata),
        .pc_word    (pc_word),
        .dmem_we    (dmem_we),
        .dmem_addr  (dmem_addr),
        .dmem_wdata (dmem_wdata),
        .running    (running),
        .halted     (halted)
    );

endmodule

//--- sort_vectors.txt
# kind name a b c, numbers in hex
# S status a=expect, P imem a=idx b=word, D dmem write+readback, E dmem a=idx b=expect
# U unmapped a=paddr, R start+halt a=budget, B start+locked probes b=idx c=word
S reset_status 0 0 0
D host_rw 14 5a5a5a5a 0
D host_rw 15 ffffffff 0
P load_sort 0 00500093 0
P load_sort 1 00000113 0
P load_sort 2 00500193 0
P load_sort 3 00012203 0
P load_sort 4 00112283 0
P load_sort 5 0042d663 0
P load_sort 6 00512023 0
P load_sort 7 004120a3 0
P load_sort 8 00110113 0
P load_sort 9 fff18193 0
P load_sort a fe0192e3 0
P load_sort b fff08093 0
P load_sort c fc009ae3 0
P load_sort d 0000006f 0
D load_array 0 00000007 0
D load_array 1 fffffffd 0
D load_array 2 00000064 0
D load_array 3 00000000 0
D load_array 4 ffffffce 0
D load_array 5 0000002a 0
B locked_run 190 14 deadbeef
S halt_status 2 0 0
E locked_unchanged 14 5a5a5a5a 0
E sort_result 0 ffffffce 0
E sort_result 1 fffffffd 0
E sort_result 2 00000000 0
E sort_result 3 00000007 0
E sort_result 4 0000002a 0
E sort_result 5 00000064 0
P load_alu 0 01900093 0
P load_alu 1 ffa00113 0
P load_alu 2 002081b3 0
P load_alu 3 40208233 0
P load_alu 4 0020f2b3 0
P load_alu 5 00c0f313 0
P load_alu 6 02302023 0
P load_alu 7 024020a3 0
P load_alu 8 02502123 0
P load_alu 9 026021a3 0
P load_alu a 00000393 0
P load_alu b 00208463 0
P load_alu c 00138393 0
P load_alu d 00209463 0
P load_alu e 00238393 0
P load_alu f 00114463 0
P load_alu 10 00438393 0
P load_alu 11 00115463 0
P load_alu 12 00838393 0
P load_alu 13 02702223 0
P load_alu 14 0000006f 0
R alu_run 40 0 0
E alu_result 20 00000013 0
E alu_result 21 0000001f 0
E alu_result 22 00000018 0
E alu_result 23 00000008 0
E alu_result 24 00000009 0
U unmapped 4 0 0
U unmapped 3000 0 0
D clear_result 20 00000000 0
D clear_result 24 00000000 0
R rerun 40 0 0
S rerun_status 2 0 0
E rerun_result 20 00000013 0
E rerun_result 24 00000009 0

//--- tb_sort_soc.sv
`timescale 1ns/1ps

module tb_sort_soc
    import riscv_pkg::*;
();

    localparam int clk_period = 100;
    localparam int max_recs   = 128;
    // spare cycles on top of the vector file's own budget
    localparam int margin_cyc = 200;

    logic   clk;
    logic   rst;
    logic   psel;
    logic   penable;
    logic   pwrite;
    paddr_t paddr;
    xlen_t  pwdata;
    xlen_t  prdata;
    logic   pready;
    logic   pslverr;
    logic   running;
    logic   halted;

    // records from the vector file
    logic [7:0]   rec_kind [max_recs];
    logic [191:0] rec_name [max_recs];
    logic [31:0]  rec_a [max_recs];
    logic [31:0]  rec_b [max_recs];
    logic [31:0]  rec_c [max_recs];
    int           rec_count;

    // bookkeeping
    int           errors;
    int           tests;
    int           failed_tests;
    int           test_err_base;
    logic [191:0] cur_name;
    longint       limit_ns = 0;

    sort_soc i_sort_soc (
        .clk     (clk),
        .rst     (rst),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr),
        .running (running),
        .halted  (halted)
    );

    // 100 ns clock
    initial begin
        clk = 1'b0;
        forever begin
            #(clk_period / 2) clk = ~clk;
        end
    end

    // watchdog, armed once the vectors are loaded
    initial begin
        wait (limit_ns != 0);
        #(limit_ns);
        $display("timeout: simulation still busy after %0d ns", limit_ns);
        $display("Errors found");
        $finish;
    end

    ////////////////////////////////////////////////////////////////////////////
    // helpers
    ////////////////////////////////////////////////////////////////////////////

    task automatic check_value(input logic [191:0] name, input xlen_t expected,
                               input xlen_t actual);
        if (expected !== actual) begin
            $display("FAILED %0s: expected %h, actual %h", name, expected, actual);
            errors++;
        end
    endtask

    // byte address of a word index in each region
    function automatic paddr_t imem_paddr(input logic [31:0] idx);
        return imem_base | paddr_t'({idx[7:0], 2'b00});
    endfunction

    function automatic paddr_t dmem_paddr(input logic [31:0] idx);
        return dmem_base | paddr_t'({idx[7:0], 2'b00});
    endfunction

    // setup, access, then idle, all on falling edges
    // response sampled in the middle of the access phase
    task automatic apb_write(input paddr_t addr, input xlen_t data, output logic err);
        @(negedge clk);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b1;
        paddr   = addr;
        pwdata  = data;
        @(negedge clk);
        penable = 1'b1;
        #(clk_period / 4);
        err = pslverr;
        // no wait states, so ready in every access phase
        check_value(cur_name, 32'd1, {31'd0, pready});
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic apb_read(input paddr_t addr, output xlen_t data, output logic err);
        @(negedge clk);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = addr;
        @(negedge clk);
        penable = 1'b1;
        #(clk_period / 4);
        data = prdata;
        err  = pslverr;
        check_value(cur_name, 32'd1, {31'd0, pready});
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic start_core(input logic [191:0] name);
        logic err;
        apb_write(ctrl_addr, 32'h1, err);
        check_value(name, 32'd0, {31'd0, err});
        // core runs from the edge that ends the access phase
        check_value(name, 32'd1, {31'd0, running});
    endtask

    // halted polled once per falling edge
    task automatic wait_halt(input logic [191:0] name, input int budget);
        int n;
        n = 0;
        while (!halted && n < budget) begin
            @(negedge clk);
            n++;
        end
        if (!halted) begin
            $display("%0s: core did not halt within %0d cycles", name, budget);
            errors++;
        end
    endtask

    task automatic close_test();
        tests++;
        if (errors != test_err_base) begin
            failed_tests++;
            $display("test %0s: failed", cur_name);
        end else begin
            $display("test %0s: ok", cur_name);
        end
        test_err_base = errors;
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // vector file
    ////////////////////////////////////////////////////////////////////////////

    task automatic load_vectors();
        int           fd;
        int           n;
        string        line;
        logic [7:0]   kind;
        logic [191:0] name;
        logic [31:0]  a;
        logic [31:0]  b;
        logic [31:0]  c;
        fd = $fopen("sort_vectors.txt", "r");
        if (fd == 0) begin
            $display("could not open sort_vectors.txt");
            errors++;
        end else begin
            while (!$feof(fd) && rec_count < max_recs) begin
                line = "";
                n = $fgets(line, fd);
                n = $sscanf(line, "%s %s %h %h %h", kind, name, a, b, c);
                // comment and blank lines never give five fields
                if (n == 5 && kind != "#") begin
                    rec_kind[rec_count] = kind;
                    rec_name[rec_count] = name;
                    rec_a[rec_count]    = a;
                    rec_b[rec_count]    = b;
                    rec_c[rec_count]    = c;
                    rec_count++;
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic run_record(input int i);
        logic         err;
        xlen_t        data;
        logic [191:0] name;
        name = rec_name[i];
        case (rec_kind[i])
            "S": begin
                apb_read(ctrl_addr, data, err);
                check_value(name, 32'd0, {31'd0, err});
                check_value(name, rec_a[i], data);
                // status pins carry the same two bits
                check_value(name, rec_a[i], {30'd0, halted, running});
            end
            "P": begin
                apb_write(imem_paddr(rec_a[i]), rec_b[i], err);
                check_value(name, 32'd0, {31'd0, err});
            end
            "D": begin
                apb_write(dmem_paddr(rec_a[i]), rec_b[i], err);
                check_value(name, 32'd0, {31'd0, err});
                apb_read(dmem_paddr(rec_a[i]), data, err);
                check_value(name, 32'd0, {31'd0, err});
                check_value(name, rec_b[i], data);
            end
            "E": begin
                apb_read(dmem_paddr(rec_a[i]), data, err);
                check_value(name, 32'd0, {31'd0, err});
                check_value(name, rec_b[i], data);
            end
            "U": begin
                apb_write(rec_a[i][15:0], 32'h0, err);
                check_value(name, 32'd1, {31'd0, err});
                apb_read(rec_a[i][15:0], data, err);
                check_value(name, 32'd1, {31'd0, err});
            end
            "R": begin
                start_core(name);
                wait_halt(name, rec_a[i]);
            end
            "B": begin
                start_core(name);
                // running bit only
                apb_read(ctrl_addr, data, err);
                check_value(name, 32'h1, data);
                // memory regions belong to the core now
                apb_write(dmem_paddr(rec_b[i]), rec_c[i], err);
                check_value(name, 32'd1, {31'd0, err});
                apb_read(dmem_paddr(rec_b[i]), data, err);
                check_value(name, 32'd1, {31'd0, err});
                apb_write(imem_paddr(rec_b[i]), rec_c[i], err);
                check_value(name, 32'd1, {31'd0, err});
                wait_halt(name, rec_a[i]);
            end
            default: begin
                $display("%0s: unknown record kind in vector file", name);
                errors++;
            end
        endcase
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // main sequence
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        int cycles;
        rst           = 1'b1;
        psel          = 1'b0;
        penable       = 1'b0;
        pwrite        = 1'b0;
        paddr         = '0;
        pwdata        = '0;
        rec_count     = 0;
        errors        = 0;
        tests         = 0;
        failed_tests  = 0;
        test_err_base = 0;
        cur_name      = '0;

        load_vectors();

        // reset, four cycles per record, run budgets, spare
        cycles = 10 + margin_cyc;
        for (int i = 0; i < rec_count; i++) begin
            cycles += 4;
            if (rec_kind[i] == "R" || rec_kind[i] == "B") begin
                cycles += int'(rec_a[i]);
            end
        end
        limit_ns = longint'(cycles) * clk_period;

        repeat (10) @(negedge clk);
        rst = 1'b0;

        // a test is a run of records with the same name
        for (int i = 0; i < rec_count; i++) begin
            if (rec_name[i] != cur_name) begin
                if (cur_name != '0) begin
                    close_test();
                end
                cur_name = rec_name[i];
            end
            run_record(i);
        end
        if (cur_name != '0) begin
            close_test();
        end

        $display("tests %0d, failed tests %0d, errors %0d", tests, failed_tests, errors);
        if (errors == 0 && tests > 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule
